// File: sim.f
+incdir+source
source/img_pkg.sv
source/fletcher_checksum.sv
source/frame_bank.sv
source/pixel_capture.sv
source/readout_sequencer.sv
source/img_controller.sv
bench/tb_img_controller.sv

// File: run_sim.sh
#!/bin/sh
# Build the image controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_img_controller \
    -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
exit 0

// File: bench/tb_img_controller.sv
`include "img_params.svh"

module tb_img_controller;
    localparam int NUM_TESTS       = 5;
    localparam int CLK_HALF        = 20;
    localparam int RESET_CYCLES    = 10;
    localparam int FV_LEAD         = 2;
    localparam int LINE_GAP        = 4;
    localparam int FRAME_GAP       = 8;
    localparam int FRAME_CYCLES    = FV_LEAD + `IMG_HEIGHT * (`IMG_WIDTH + LINE_GAP) + FRAME_GAP;
    localparam int STREAM_WORDS    = `HEADER_WORDS + `PIXEL_COUNT + `CHECKSUM_WORDS
                                     + `PADDING_WORDS;
    localparam int READOUT_TIMEOUT = 8 * STREAM_WORDS;
    localparam int TEST_CYCLES     = 2 * FRAME_CYCLES + READOUT_TIMEOUT + 16;
    localparam int WATCHDOG_LIMIT  = (RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * 2 * CLK_HALF;

    typedef struct packed {
        logic                        readout;
        logic                        bank;
        logic                        skip;
        logic                        thumb;
        logic [`HEADER_WORDS*16-1:0] header;
        logic [7:0]                  duty;
    } test_entry_t;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        cmd_capture;
    logic                        cmd_readout;
    logic                        cmd_bank;
    logic                        cmd_skip_count;
    logic [`HEADER_WORDS*16-1:0] cmd_header;
    logic                        cmd_thumb;
    img_pkg::sensor_t            sensor;
    img_pkg::capture_status_t    capture_status;
    logic                        capture_done;
    logic [15:0]                 readout_data;
    logic                        readout_ready;
    logic                        readout_trigger;

    test_entry_t tests [NUM_TESTS];
    string       test_names [NUM_TESTS];
    logic [11:0] frame_pix [`PIXEL_COUNT];
    logic [11:0] ref_bank [`BANK_COUNT][`PIXEL_COUNT];
    logic [15:0] exp_q [$];
    logic [31:0] rng;
    int          ck_lo;
    int          ck_hi;
    int          checks = 0;
    int          errors = 0;
    int          done_count = 0;

    img_controller DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_capture     (cmd_capture),
        .cmd_readout     (cmd_readout),
        .cmd_bank        (cmd_bank),
        .cmd_skip_count  (cmd_skip_count),
        .cmd_header      (cmd_header),
        .cmd_thumb       (cmd_thumb),
        .sensor          (sensor),
        .capture_status  (capture_status),
        .capture_done    (capture_done),
        .readout_data    (readout_data),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger)
    );

    always #(CLK_HALF) clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && capture_done) begin
            done_count++;
        end
    end

    // ==================================================
    // Helpers
    // ==================================================
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [15:0] byte_swap(input logic [15:0] w);
        return {w[7:0], w[15:8]};
    endfunction

    // Some pixels pushed to the highlight or shadow range
    function automatic logic [11:0] make_pixel(input logic [31:0] r);
        logic [11:0] d;
        d = r[27:16];
        case (r[30:29])
            2'd0: d = d | 12'hFE0;
            2'd1: d = d & 12'h01F;
            default: begin
            end
        endcase
        return d;
    endfunction

    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %s expected %0h actual %0h", what, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic sum_word(input logic [15:0] w);
        ck_lo = (ck_lo + int'(byte_swap(w))) % 65535;
        ck_hi = (ck_hi + ck_lo) % 65535;
    endtask

    // Sensor model sending one full frame with gaps
    task automatic send_frame;
        int r;
        int c;
        sensor = '{data: '0, fv: 1'b1, lv: 1'b0};
        repeat (FV_LEAD) next_cycle();
        for (r = 0; r < `IMG_HEIGHT; r++) begin
            for (c = 0; c < `IMG_WIDTH; c++) begin
                rng = lcg_step(rng);
                frame_pix[r * `IMG_WIDTH + c] = make_pixel(rng);
                sensor = '{data: frame_pix[r * `IMG_WIDTH + c], fv: 1'b1, lv: 1'b1};
                next_cycle();
            end
            sensor = '{data: '0, fv: 1'b1, lv: 1'b0};
            repeat (LINE_GAP) next_cycle();
        end
        sensor = '0;
        repeat (FRAME_GAP) next_cycle();
    endtask

    task automatic fill_table;
        test_names[0] = "capture_b0_skip0";
        tests[0] = '{readout: 1'b0, bank: 1'b0, skip: 1'b0, thumb: 1'b0,
                     header: '0, duty: 8'd100};
        test_names[1] = "readout_b0_full";
        tests[1] = '{readout: 1'b1, bank: 1'b0, skip: 1'b0, thumb: 1'b0,
                     header: 128'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210, duty: 8'd100};
        test_names[2] = "capture_b1_skip1";
        tests[2] = '{readout: 1'b0, bank: 1'b1, skip: 1'b1, thumb: 1'b0,
                     header: '0, duty: 8'd100};
        test_names[3] = "readout_b1_thumb";
        tests[3] = '{readout: 1'b1, bank: 1'b1, skip: 1'b0, thumb: 1'b1,
                     header: 128'hFFFF_0000_A5A5_5A5A_1357_2468_C0DE_BEEF, duty: 8'd100};
        test_names[4] = "readout_b0_stall";
        tests[4] = '{readout: 1'b1, bank: 1'b0, skip: 1'b0, thumb: 1'b0,
                     header: 128'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210, duty: 8'd35};
    endtask

    // ==================================================
    // Capture and readout tests
    // ==================================================
    task automatic run_capture(input int t);
        test_entry_t e;
        int          done_before;
        int          k;
        int          r;
        int          c;
        int          hl;
        int          sh;
        logic [6:0]  top;
        e = tests[t];
        done_before = done_count;
        cmd_bank = e.bank;
        cmd_skip_count = e.skip;
        cmd_capture = 1'b1;
        next_cycle();
        cmd_capture = 1'b0;
        repeat (2) next_cycle();
        // The last frame sent is the stored one
        for (k = 0; k <= int'(e.skip); k++) begin
            send_frame();
        end
        for (k = 0; k < `PIXEL_COUNT; k++) begin
            ref_bank[e.bank][k] = frame_pix[k];
        end
        k = 0;
        while (done_count == done_before && k < FRAME_CYCLES) begin
            next_cycle();
            k++;
        end
        if (done_count == done_before) begin
            report_failure($sformatf("%s: capture_done never pulsed", test_names[t]));
        end
        repeat (4) next_cycle();
        compare({test_names[t], " done pulses"}, 1, done_count - done_before);
        hl = 0;
        sh = 0;
        for (r = 0; r < `IMG_HEIGHT; r += `STAT_GRID) begin
            for (c = 0; c < `IMG_WIDTH; c += `STAT_GRID) begin
                top = frame_pix[r * `IMG_WIDTH + c][11:5];
                hl += (top == 7'h7F) ? 1 : 0;
                sh += (top == 7'h00) ? 1 : 0;
            end
        end
        compare({test_names[t], " pixel count"}, `PIXEL_COUNT, capture_status.pixel_count);
        compare({test_names[t], " highlights"}, hl, capture_status.highlight_count);
        compare({test_names[t], " shadows"}, sh, capture_status.shadow_count);
    endtask

    task automatic build_expected(input test_entry_t e);
        int          i;
        int          r;
        int          c;
        logic [11:0] d;
        logic [15:0] w;
        exp_q.delete();
        ck_lo = 0;
        ck_hi = 0;
        for (i = 0; i < `HEADER_WORDS; i++) begin
            w = e.header[(`HEADER_WORDS - 1 - i) * 16 +: 16];
            exp_q.push_back(w);
            sum_word(w);
        end
        for (r = 0; r < `IMG_HEIGHT; r++) begin
            for (c = 0; c < `IMG_WIDTH; c++) begin
                if (!e.thumb || ((c % `THUMB_GROUP) < `THUMB_KEEP
                                 && (r % `THUMB_GROUP) < `THUMB_KEEP)) begin
                    d = ref_bank[e.bank][r * `IMG_WIDTH + c];
                    w = {d[7:0], 4'b0000, d[11:8]};
                    exp_q.push_back(w);
                    sum_word(w);
                end
            end
        end
        exp_q.push_back(byte_swap(ck_lo[15:0]));
        exp_q.push_back(byte_swap(ck_hi[15:0]));
        for (i = 0; i < `PADDING_WORDS; i++) begin
            exp_q.push_back(16'h0000);
        end
    endtask

    task automatic run_readout(input int t);
        test_entry_t e;
        int          got;
        int          cycles;
        int          first_ready;
        int          extra;
        e = tests[t];
        build_expected(e);
        cmd_bank = e.bank;
        cmd_header = e.header;
        cmd_thumb = e.thumb;
        cmd_readout = 1'b1;
        next_cycle();
        cmd_readout = 1'b0;
        got = 0;
        cycles = 0;
        first_ready = -1;
        while (got < exp_q.size() && cycles < READOUT_TIMEOUT) begin
            rng = lcg_step(rng);
            readout_trigger = ((rng[30:16] % 15'd100) < e.duty);
            if (readout_ready && first_ready < 0) begin
                first_ready = cycles;
            end
            if (readout_ready && readout_trigger) begin
                compare($sformatf("%s word %0d", test_names[t], got), exp_q[got], readout_data);
                got++;
            end
            next_cycle();
            cycles++;
        end
        if (got < exp_q.size()) begin
            report_failure($sformatf("%s: readout stopped after %0d of %0d words",
                                     test_names[t], got, exp_q.size()));
        end
        if (first_ready > 3) begin
            report_failure($sformatf("%s: first word came %0d cycles after the command",
                                     test_names[t], first_ready));
        end
        // Stream must end exactly here
        readout_trigger = 1'b1;
        extra = 0;
        repeat (4) begin
            extra += readout_ready ? 1 : 0;
            next_cycle();
        end
        readout_trigger = 1'b0;
        if (extra != 0) begin
            report_failure($sformatf("%s: %0d words past the end of the stream",
                                     test_names[t], extra));
        end
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================
    initial begin
        int t;
        rst_n = 1'b0;
        cmd_capture = 1'b0;
        cmd_readout = 1'b0;
        cmd_bank = 1'b0;
        cmd_skip_count = 1'b0;
        cmd_header = '0;
        cmd_thumb = 1'b0;
        sensor = '0;
        readout_trigger = 1'b0;
        rng = 32'd2652;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (2) next_cycle();
        for (t = 0; t < NUM_TESTS; t++) begin
            if (tests[t].readout) begin
                run_readout(t);
            end else begin
                run_capture(t);
            end
            repeat (4) next_cycle();
        end
        $display("Closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_LIMIT);
        $display("Watchdog expired before the tests finished, %0d errors so far", errors);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: source/img_controller.sv
`include "img_params.svh"

module img_controller (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cmd_capture,
    input  logic                        cmd_readout,
    input  logic                        cmd_bank,
    input  logic                        cmd_skip_count,
    input  logic [`HEADER_WORDS*16-1:0] cmd_header,
    input  logic                        cmd_thumb,
    input  img_pkg::sensor_t            sensor,
    output img_pkg::capture_status_t    capture_status,
    output logic                        capture_done,
    output logic [15:0]                 readout_data,
    output logic                        readout_ready,
    input  logic                        readout_trigger
);
    img_pkg::bank_write_t bank_wr;
    img_pkg::bank_read_t  bank_rd;
    img_pkg::pixel_word_t bank_data [`BANK_COUNT];

    pixel_capture u_capture (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_capture    (cmd_capture),
        .cmd_bank       (cmd_bank),
        .cmd_skip_count (cmd_skip_count),
        .sensor         (sensor),
        .bank_wr        (bank_wr),
        .capture_status (capture_status),
        .capture_done   (capture_done)
    );

    // Every bank sees both requests and decodes its own index
    for (genvar i = 0; i < `BANK_COUNT; i++) begin : g_bank
        frame_bank #(
            .BANK_INDEX (i)
        ) u_bank (
            .clk     (clk),
            .bank_wr (bank_wr),
            .bank_rd (bank_rd),
            .rd_data (bank_data[i])
        );
    end

    readout_sequencer u_sequencer (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_readout     (cmd_readout),
        .cmd_bank        (cmd_bank),
        .cmd_header      (cmd_header),
        .cmd_thumb       (cmd_thumb),
        .bank_rd         (bank_rd),
        .bank_data       (bank_data),
        .readout_data    (readout_data),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger)
    );

endmodule

// File: source/readout_sequencer.sv
`include "img_params.svh"

module readout_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cmd_readout,
    input  logic                        cmd_bank,
    input  logic [`HEADER_WORDS*16-1:0] cmd_header,
    input  logic                        cmd_thumb,
    output img_pkg::bank_read_t         bank_rd,
    input  img_pkg::pixel_word_t        bank_data [`BANK_COUNT],
    output logic [15:0]                 readout_data,
    output logic                        readout_ready,
    input  logic                        readout_trigger
);
    localparam int COL_W = $clog2(`IMG_WIDTH);
    localparam int ROW_W = $clog2(`IMG_HEIGHT);
    localparam logic [COL_W-1:0] COL_LAST = COL_W'(`IMG_WIDTH - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_HEADER,
        S_PIXELS,
        S_CHECKSUM,
        S_PADDING
    } state_t;

    state_t                         state;
    logic [`HEADER_WORDS*16-1:0]    hdr_sr;
    logic [5:0]                     sec_cnt;
    logic                           thumb;
    logic [$clog2(`BANK_COUNT)-1:0] rd_bank;
    logic [$clog2(`BANK_COUNT)-1:0] rd_bank_q;
    logic [COL_W-1:0]               col;
    logic [ROW_W:0]                 row;
    logic                           rd_pending;
    logic                           skid_valid;
    img_pkg::pixel_word_t           skid_data;
    img_pkg::pixel_word_t           ret_word;
    logic                           out_ck;
    logic                           slot_free;
    logic                           keep;
    logic                           pix_left;
    logic                           issue;
    logic                           load;
    logic [15:0]                    load_word;
    logic                           ck_en;
    logic [31:0]                    ck_sum;

    // Output register can take a word when empty or draining
    assign slot_free = !readout_ready || readout_trigger;
    assign pix_left  = (row != `IMG_HEIGHT);
    assign keep      = !thumb
        || (((col % `THUMB_GROUP) < `THUMB_KEEP) && ((row % `THUMB_GROUP) < `THUMB_KEEP));

    // A read is only started while the skid slot is free, which bounds
    // the words in flight to the bank output plus the skid
    assign issue   = (state == S_PIXELS) && pix_left && keep && slot_free && !skid_valid;
    assign bank_rd = '{rd: issue, bank: rd_bank, addr: {row[ROW_W-1:0], col}};

    // Returned word picked by the bank of the previous request
    assign ret_word = bank_data[rd_bank_q];

    // ==================================================
    // Checksum over delivered header and pixel words
    // ==================================================
    assign ck_en = readout_ready && readout_trigger && out_ck;

    fletcher_checksum u_checksum (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (cmd_readout),
        .en    (ck_en),
        .din   ({readout_data[7:0], readout_data[15:8]}),
        .sum   (ck_sum)
    );

    // Next word for the output register
    always_comb begin
        load      = 1'b0;
        load_word = '0;
        case (state)
            S_HEADER: begin
                load      = slot_free;
                load_word = hdr_sr[`HEADER_WORDS*16-1 -: 16];
            end
            S_PIXELS: begin
                if (skid_valid) begin
                    load      = slot_free;
                    load_word = skid_data;
                end else if (rd_pending) begin
                    load      = slot_free;
                    load_word = ret_word;
                end
            end
            S_CHECKSUM: begin
                load = slot_free;
                if (sec_cnt == '0) begin
                    load_word = {ck_sum[7:0], ck_sum[15:8]};
                end else begin
                    load_word = {ck_sum[23:16], ck_sum[31:24]};
                end
            end
            S_PADDING: begin
                load = slot_free;
            end
            default: begin
            end
        endcase
    end

    // ==================================================
    // Section FSM and output register
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            readout_ready <= 1'b0;
            rd_pending    <= 1'b0;
            skid_valid    <= 1'b0;
            out_ck        <= 1'b0;
            sec_cnt       <= '0;
            col           <= '0;
            row           <= '0;
            thumb         <= 1'b0;
            rd_bank       <= '0;
        end else if (cmd_readout) begin
            state         <= S_HEADER;
            readout_ready <= 1'b0;
            rd_pending    <= 1'b0;
            skid_valid    <= 1'b0;
            sec_cnt       <= '0;
            col           <= '0;
            row           <= '0;
            thumb         <= cmd_thumb;
            rd_bank       <= cmd_bank;
            hdr_sr        <= cmd_header;
        end else begin
            if (load) begin
                readout_data  <= load_word;
                readout_ready <= 1'b1;
                out_ck        <= (state == S_HEADER) || (state == S_PIXELS);
            end else if (readout_trigger) begin
                readout_ready <= 1'b0;
            end

            rd_pending <= issue;
            if (issue) begin
                rd_bank_q <= rd_bank;
            end

            case (state)
                S_HEADER: begin
                    if (load) begin
                        hdr_sr  <= hdr_sr << 16;
                        sec_cnt <= sec_cnt + 1'b1;
                        if (sec_cnt == 6'(`HEADER_WORDS - 1)) begin
                            sec_cnt <= '0;
                            state   <= S_PIXELS;
                        end
                    end
                end
                S_PIXELS: begin
                    // Dropped thumbnail positions advance without a read
                    if (pix_left && (issue || !keep)) begin
                        col <= col + 1'b1;
                        if (col == COL_LAST) begin
                            row <= row + 1'b1;
                        end
                    end
                    if (skid_valid) begin
                        if (slot_free) begin
                            skid_valid <= 1'b0;
                        end
                    end else if (rd_pending && !slot_free) begin
                        skid_valid <= 1'b1;
                        skid_data  <= ret_word;
                    end
                    // Last pixel has moved, so the checksum already holds it
                    if (!pix_left && !rd_pending && !skid_valid && !readout_ready) begin
                        state <= S_CHECKSUM;
                    end
                end
                S_CHECKSUM: begin
                    if (load) begin
                        sec_cnt <= sec_cnt + 1'b1;
                        if (sec_cnt == 6'(`CHECKSUM_WORDS - 1)) begin
                            sec_cnt <= '0;
                            state   <= S_PADDING;
                        end
                    end
                end
                S_PADDING: begin
                    if (load) begin
                        sec_cnt <= sec_cnt + 1'b1;
                        if (sec_cnt == 6'(`PADDING_WORDS - 1)) begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Back-pressure holds the presented word
    assert property (@(posedge clk) disable iff (!rst_n || cmd_readout)
        readout_ready && !readout_trigger |=> readout_ready && $stable(readout_data));

endmodule

// File: source/pixel_capture.sv
`include "img_params.svh"

module pixel_capture (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cmd_capture,
    input  logic                     cmd_bank,
    input  logic                     cmd_skip_count,
    input  img_pkg::sensor_t         sensor,
    output img_pkg::bank_write_t     bank_wr,
    output img_pkg::capture_status_t capture_status,
    output logic                     capture_done
);
    localparam int COL_W = $clog2(`IMG_WIDTH);
    localparam int ROW_W = $clog2(`IMG_HEIGHT);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ARM,
        S_WAIT_FRAME,
        S_SKIP_CHECK,
        S_STORE
    } state_t;

    state_t                         state;
    img_pkg::sensor_t               sens_q;
    logic [$clog2(`BANK_COUNT)-1:0] cap_bank;
    logic                           skip_left;
    logic [COL_W-1:0]               col;
    logic [ROW_W-1:0]               row;
    logic                           frame_start;
    logic                           line_end;
    logic                           store_active;
    logic                           pixel_wr;
    logic                           on_grid;
    logic [6:0]                     top_bits;

    // Edges are found by comparing the live input against the registered copy,
    // so the decision is ready when the edge sample reaches sens_q
    assign frame_start = sensor.fv && !sens_q.fv;
    assign line_end    = sens_q.lv && !sensor.lv;

    // First sample of the frame is in sens_q while the skip check runs
    assign store_active = (state == S_STORE) || (state == S_SKIP_CHECK && !skip_left);
    assign pixel_wr     = store_active && sens_q.lv;

    assign on_grid  = ((col % `STAT_GRID) == 0) && ((row % `STAT_GRID) == 0);
    assign top_bits = sens_q.data[`PIXEL_BITS-1 -: 7];

    // ==================================================
    // Sensor register and pixel position
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sens_q <= '0;
            col    <= '0;
            row    <= '0;
        end else begin
            sens_q <= sensor;
            col    <= sens_q.lv ? col + 1'b1 : '0;
            if (!sens_q.fv) begin
                row <= '0;
            end else if (line_end) begin
                row <= row + 1'b1;
            end
        end
    end

    // ==================================================
    // Capture FSM and statistics
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= S_IDLE;
            capture_done   <= 1'b0;
            capture_status <= '0;
            cap_bank       <= '0;
            skip_left      <= 1'b0;
        end else begin
            capture_done <= 1'b0;

            if (pixel_wr) begin
                capture_status.pixel_count <= capture_status.pixel_count + 1'b1;
                if (on_grid && (&top_bits)) begin
                    capture_status.highlight_count <= capture_status.highlight_count + 1'b1;
                end
                if (on_grid && top_bits == '0) begin
                    capture_status.shadow_count <= capture_status.shadow_count + 1'b1;
                end
            end

            case (state)
                S_ARM: begin
                    capture_status <= '0;
                    state <= frame_start ? S_SKIP_CHECK : S_WAIT_FRAME;
                end
                S_WAIT_FRAME: begin
                    if (frame_start) begin
                        state <= S_SKIP_CHECK;
                    end
                end
                S_SKIP_CHECK: begin
                    if (skip_left) begin
                        skip_left <= skip_left - 1'b1;
                        state     <= S_WAIT_FRAME;
                    end else begin
                        state <= S_STORE;
                    end
                end
                S_STORE: begin
                    if (!sens_q.fv) begin
                        capture_done <= 1'b1;
                        state        <= S_IDLE;
                    end
                end
                default: begin
                end
            endcase

            // A new command restarts from any state
            if (cmd_capture) begin
                state     <= S_ARM;
                cap_bank  <= cmd_bank;
                skip_left <= cmd_skip_count;
            end
        end
    end

    // Low data byte first, then the top nibble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank_wr.valid <= 1'b0;
        end else begin
            bank_wr.valid <= pixel_wr;
        end
        bank_wr.bank <= cap_bank;
        bank_wr.addr <= capture_status.pixel_count[`BANK_ADDR_WIDTH-1:0];
        bank_wr.data <= {sens_q.data[7:0], 4'b0000, sens_q.data[`PIXEL_BITS-1:8]};
    end

    // Count runs one ahead of the address it just issued
    assert property (@(posedge clk) disable iff (!rst_n)
        bank_wr.valid |-> capture_status.pixel_count <= `PIXEL_COUNT);

endmodule

// File: source/frame_bank.sv
`include "img_params.svh"

module frame_bank #(
    parameter int BANK_INDEX = 0
) (
    input  logic                 clk,
    input  img_pkg::bank_write_t bank_wr,
    input  img_pkg::bank_read_t  bank_rd,
    output img_pkg::pixel_word_t rd_data
);
    img_pkg::pixel_word_t mem [`PIXEL_COUNT];

    logic wr_hit;
    logic rd_hit;
    logic same_addr;

    assign wr_hit    = bank_wr.valid && (int'(bank_wr.bank) == BANK_INDEX);
    assign rd_hit    = bank_rd.rd && (int'(bank_rd.bank) == BANK_INDEX);
    assign same_addr = (bank_wr.addr == bank_rd.addr);

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            mem[bank_wr.addr] <= bank_wr.data;
        end
    end

    // Registered read where new data wins on a collision
    always_ff @(posedge clk) begin
        if (rd_hit) begin
            if (wr_hit && same_addr) begin
                rd_data <= bank_wr.data;
            end else begin
                rd_data <= mem[bank_rd.addr];
            end
        end
    end

    // Capture and readout never touch the same word at once
    assert property (@(posedge clk) !(wr_hit && rd_hit && same_addr));

endmodule

// File: source/fletcher_checksum.sv
module fletcher_checksum (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,
    input  logic        en,
    input  logic [15:0] din,
    output logic [31:0] sum
);
    logic [15:0] sum_lo;
    logic [15:0] sum_hi;
    logic [15:0] lo_next;

    // One's complement style add, modulo 65535
    function automatic logic [15:0] add_mod(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= 17'd65535) begin
            s = s - 17'd65535;
        end
        return s[15:0];
    endfunction

    assign lo_next = add_mod(sum_lo, din);
    assign sum     = {sum_hi, sum_lo};

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            sum_lo <= '0;
            sum_hi <= '0;
        end else if (en) begin
            sum_lo <= lo_next;
            sum_hi <= add_mod(sum_hi, lo_next);
        end
    end

endmodule

// File: source/img_pkg.sv
`include "img_params.svh"

package img_pkg;

    // One stored pixel in little-endian packing
    typedef logic [15:0] pixel_word_t;

    // Capture to banks
    typedef struct packed {
        logic                           valid;
        logic [$clog2(`BANK_COUNT)-1:0] bank;
        logic [`BANK_ADDR_WIDTH-1:0]    addr;
        pixel_word_t                    data;
    } bank_write_t;

    // Sequencer to banks
    typedef struct packed {
        logic                           rd;
        logic [$clog2(`BANK_COUNT)-1:0] bank;
        logic [`BANK_ADDR_WIDTH-1:0]    addr;
    } bank_read_t;

    typedef struct packed {
        logic [`BANK_ADDR_WIDTH:0] pixel_count;
        logic [`STAT_WIDTH-1:0]    highlight_count;
        logic [`STAT_WIDTH-1:0]    shadow_count;
    } capture_status_t;

    typedef struct packed {
        logic [`PIXEL_BITS-1:0] data;
        logic                   fv;
        logic                   lv;
    } sensor_t;

endpackage

// File: source/img_params.svh
`ifndef IMG_PARAMS_SVH
`define IMG_PARAMS_SVH

// Image geometry cut down for simulation
`define IMG_WIDTH        16
`define IMG_HEIGHT       8
`define PIXEL_COUNT      128
`define PIXEL_BITS       12

// Frame banks
`define BANK_ADDR_WIDTH  7
`define BANK_COUNT       2

// Readout stream layout in 16-bit words
`define HEADER_WORDS     8
`define CHECKSUM_WORDS   2
`define PADDING_WORDS    42

// Statistics and thumbnail rules
`define STAT_WIDTH       18
`define STAT_GRID        4
`define THUMB_GROUP      8
`define THUMB_KEEP       2

`endif
